// ==== Bender.yml ====
package:
  name: ahb_subsystem

sources:
  # Packages first, then the modules that use them
  - design/ahbLitePkg.sv
  - design/coreBusPkg.sv
  - design/ifuFetcher.sv
  - design/ahbMultiManager.sv
  - design/ahbMemory.sv
  - design/ahbSubsystem.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/ahbSubsystemTb.sv

// ==== design/ahbLitePkg.sv ====
// AHB-Lite protocol definitions
// Bus widths, HTRANS and HBURST encodings, the address-phase struct
// and the fixed HSIZE and HPROT values
`default_nettype none

package ahbLitePkg;

  // Address and data widths are fixed at 32 bits
  typedef logic [31:0] hAddrT;
  typedef logic [31:0] hDataT;
  // One write strobe per data byte
  typedef logic [3:0]  hStrbT;
  typedef logic [2:0]  hSizeT;

  // HTRANS codes
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } hTransT;

  // HBURST codes, no wrapping bursts
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    INCR4  = 3'b011,
    INCR8  = 3'b101,
    INCR16 = 3'b111
  } hBurstT;

  // One address phase as a manager drives it
  typedef struct packed {
    hAddrT  haddr;
    hTransT htrans;
    hBurstT hburst;
    hSizeT  hsize;
    logic   hwrite;
  } ahbReqT;

  // 32-bit transfer
  localparam hSizeT hSizeWord = 3'b010;

  // Privileged data access, not bufferable, not cacheable
  localparam logic [3:0] hProtData = 4'b0011;

endpackage

`default_nettype wire

// ==== design/ahbMemory.sv ====
// AHB-Lite subordinate word memory
// Byte-strobed writes, word reads, fixed wait states per data phase
// Two-cycle error response above the populated range
`default_nettype none

module ahbMemory #(
  parameter int unsigned WaitStates = 1,
  parameter int unsigned MemWords   = 256
) (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire ahbLitePkg::ahbReqT busReq,
  input  wire ahbLitePkg::hDataT  hwdata,
  input  wire ahbLitePkg::hStrbT  hwstrb,
  output logic                    hready,
  output ahbLitePkg::hDataT       hrdata,
  output logic                    hresp
);

  localparam int unsigned IdxBits  = $clog2(MemWords);
  localparam int unsigned StrbBits = $bits(ahbLitePkg::hStrbT);

  typedef logic [29:0]        wordAddrT;
  typedef logic [IdxBits-1:0] wordIdxT;

  ahbLitePkg::hDataT mem [MemWords];

  // Data phase in progress
  logic       active;
  logic [1:0] waitCnt;
  logic       waitDone;
  // Second cycle of an error response
  logic       errSecond;
  wordAddrT   wordAddr;
  logic       isWrite;
  wordIdxT    wordIdx;
  logic       inRange;
  logic       accept;
  logic       phaseDone;

  ////////////////////////////////////////////////////////////
  // Address and data phase control
  ////////////////////////////////////////////////////////////

  assign accept = hready && ((busReq.htrans == ahbLitePkg::NONSEQ) ||
                             (busReq.htrans == ahbLitePkg::SEQ));

  assign wordIdx   = wordAddr[IdxBits-1:0];
  assign inRange   = (wordAddr >> IdxBits) == '0;
  assign waitDone  = waitCnt == 2'(WaitStates);
  assign hready    = !active || (waitDone && (inRange || errSecond));
  assign hresp     = active && waitDone && !inRange;
  assign phaseDone = active && hready;

  always_ff @(posedge clk) begin
    if (reset) begin
      active    <= 1'b0;
      waitCnt   <= '0;
      errSecond <= 1'b0;
    end else if (hready) begin
      // A new data phase starts only with an accepted address
      active    <= accept;
      waitCnt   <= '0;
      errSecond <= 1'b0;
    end else if (!waitDone) begin
      waitCnt <= waitCnt + 2'd1;
    end else begin
      errSecond <= 1'b1;
    end
  end

  // Accepted address phase
  always_ff @(posedge clk) begin
    if (accept) begin
      wordAddr <= busReq.haddr[31:2];
      isWrite  <= busReq.hwrite;
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Write data arrives in the data phase
  always_ff @(posedge clk) begin
    if (phaseDone && inRange && isWrite) begin
      for (int b = 0; b < StrbBits; b++) begin
        if (hwstrb[b]) begin
          mem[wordIdx][8*b +: 8] <= hwdata[8*b +: 8];
        end
      end
    end
  end

  // Zero outside the range and on writes
  assign hrdata = (active && inRange && !isWrite) ? mem[wordIdx] : '0;

  // Error is always followed by its completing cycle
  assert property (@(posedge clk) disable iff (reset)
    (hresp && !hready) |=> (hresp && hready));

endmodule

`default_nettype wire

// ==== design/ahbMultiManager.sv ====
// Two-manager AHB-Lite merger
// Fetch and load/store address phases onto one bus with LSU priority
// Save register for the losing fetch phase and the arbitration FSM
// Beat counter that finds the end of the winning burst
`default_nettype none

module ahbMultiManager (
  input  wire logic               clk,
  input  wire logic               reset,
  // Fetch manager
  input  wire ahbLitePkg::ahbReqT ifuReq,
  output logic                    ifuHready,
  // Load/store manager
  input  wire ahbLitePkg::ahbReqT lsuReq,
  input  wire ahbLitePkg::hDataT  lsuWdata,
  input  wire ahbLitePkg::hStrbT  lsuWstrb,
  output logic                    lsuHready,
  // Merged bus
  input  wire logic               hready,
  output ahbLitePkg::ahbReqT      busReq,
  output ahbLitePkg::hDataT       hwdata,
  output ahbLitePkg::hStrbT       hwstrb,
  output logic [3:0]              hprot
);

  typedef enum logic {IDLE, ARBITRATE} busStateT;

  busStateT           state;
  busStateT           nextState;

  ahbLitePkg::ahbReqT ifuSave;
  ahbLitePkg::ahbReqT ifuRestore;
  ahbLitePkg::ahbReqT ifuPhase;
  logic               ifuPending;
  logic               lsuPending;
  logic               ifuActive;
  logic               lsuActive;
  logic               both;
  logic               saveIfu;
  // Fetch held off and replayed from the save register
  logic               holdIfu;
  logic               selIfu;
  logic               selLsu;

  logic [3:0]         wordCount;
  logic [3:0]         wordCountDelayed;
  logic [3:0]         lastBeat;
  logic               wordCntEn;
  logic               cntClear;
  logic               lastBeatFlag;
  ahbLitePkg::hBurstT burstD;

  ////////////////////////////////////////////////////////////
  // Input stages
  ////////////////////////////////////////////////////////////

  // Fetch phase that loses a same-cycle request
  always_ff @(posedge clk) begin
    if (saveIfu) begin
      ifuSave <= ifuReq;
    end
  end

  assign ifuRestore = holdIfu ? ifuSave : ifuReq;
  assign ifuPending = ifuRestore.htrans != ahbLitePkg::IDLE;
  assign ifuHready  = hready & ~holdIfu;
  assign ifuActive  = ifuPending & ifuHready;

  // LSU is never held off
  assign lsuPending = lsuReq.htrans != ahbLitePkg::IDLE;
  assign lsuHready  = hready;
  assign lsuActive  = lsuPending & lsuHready;

  assign both    = ifuActive & lsuActive;
  assign saveIfu = (state == IDLE) & both;
  assign holdIfu = state == ARBITRATE;

  ////////////////////////////////////////////////////////////
  // Output mux
  ////////////////////////////////////////////////////////////

  // LSU owns the bus for the whole arbitration
  assign selLsu = (nextState == ARBITRATE) | lsuPending;
  assign selIfu = (nextState != ARBITRATE) & ifuPending;

  // Fetches are always word reads
  always_comb begin
    ifuPhase        = ifuRestore;
    ifuPhase.hsize  = ahbLitePkg::hSizeWord;
    ifuPhase.hwrite = 1'b0;
  end

  always_comb begin
    if (selLsu) begin
      busReq = lsuReq;
    end else if (selIfu) begin
      busReq = ifuPhase;
    end else begin
      busReq = '0;
    end
  end

  // Only the LSU writes
  assign hwdata = lsuWdata;
  assign hwstrb = lsuWstrb;
  assign hprot  = ahbLitePkg::hProtData;

  ////////////////////////////////////////////////////////////
  // Arbitration FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    case (state)
      IDLE:      nextState = both ? ARBITRATE : IDLE;
      // Leave once the final LSU data phase completes
      ARBITRATE: nextState = (hready & lastBeatFlag) ? IDLE : ARBITRATE;
      default:   nextState = IDLE;
    endcase
  end

  // Beats accepted during arbitration and a delayed copy for the data phases
  assign cntClear  = nextState == IDLE;
  assign wordCntEn = (nextState == ARBITRATE) & hready;

  always_ff @(posedge clk) begin
    if (reset | cntClear) begin
      wordCount        <= '0;
      wordCountDelayed <= '0;
    end else if (wordCntEn) begin
      wordCount        <= wordCount + 4'd1;
      wordCountDelayed <= wordCount;
    end
  end

  // Burst type of the last accepted first beat
  always_ff @(posedge clk) begin
    if (reset) begin
      burstD <= ahbLitePkg::SINGLE;
    end else if ((busReq.htrans == ahbLitePkg::NONSEQ) && hready) begin
      burstD <= busReq.hburst;
    end
  end

  assign lastBeat     = coreBusPkg::burstLastBeat(burstD);
  assign lastBeatFlag = wordCountDelayed == lastBeat;

  // Saved fetch phase goes out on the beat that ends arbitration
  assert property (@(posedge clk) disable iff (reset)
    (state == ARBITRATE && nextState == IDLE) |-> (selIfu && !selLsu));

endmodule

`default_nettype wire

// ==== design/ahbSubsystem.sv ====
// Two-manager AHB-Lite subsystem top level
// Fetch unit and external LSU port merged onto one memory
`default_nettype none

module ahbSubsystem #(
  parameter int unsigned WaitStates = 1,
  parameter int unsigned MemWords   = 256
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  // Fetch requests
  input  wire logic                 fetchStart,
  input  wire coreBusPkg::lineAddrT fetchAddr,
  output logic                      fetchBusy,
  output logic                      fetchDone,
  output logic                      fetchError,
  output coreBusPkg::fetchLineT     fetchLine,
  // Load/store manager
  input  wire ahbLitePkg::ahbReqT   lsuReq,
  input  wire ahbLitePkg::hDataT    lsuWdata,
  input  wire ahbLitePkg::hStrbT    lsuWstrb,
  output logic                      lsuHready,
  output ahbLitePkg::hDataT         lsuHrdata,
  output logic                      lsuHresp,
  output logic [3:0]                hprot
);

  ahbLitePkg::ahbReqT ifuReq;
  logic               ifuHready;
  ahbLitePkg::ahbReqT busReq;
  ahbLitePkg::hDataT  hwdata;
  ahbLitePkg::hStrbT  hwstrb;
  logic               hready;
  ahbLitePkg::hDataT  hrdata;
  logic               hresp;

  // Read data and response are shared by both managers
  assign lsuHrdata = hrdata;
  assign lsuHresp  = hresp;

  ifuFetcher ifu0 (
    .clk        (clk),
    .reset      (reset),
    .fetchStart (fetchStart),
    .fetchAddr  (fetchAddr),
    .fetchBusy  (fetchBusy),
    .fetchDone  (fetchDone),
    .fetchError (fetchError),
    .fetchLine  (fetchLine),
    .ifuReq     (ifuReq),
    .ifuHready  (ifuHready),
    .hrdata     (hrdata),
    .hresp      (hresp)
  );

  ahbMultiManager merge0 (
    .clk       (clk),
    .reset     (reset),
    .ifuReq    (ifuReq),
    .ifuHready (ifuHready),
    .lsuReq    (lsuReq),
    .lsuWdata  (lsuWdata),
    .lsuWstrb  (lsuWstrb),
    .lsuHready (lsuHready),
    .hready    (hready),
    .busReq    (busReq),
    .hwdata    (hwdata),
    .hwstrb    (hwstrb),
    .hprot     (hprot)
  );

  ahbMemory #(
    .WaitStates (WaitStates),
    .MemWords   (MemWords)
  ) mem0 (
    .clk    (clk),
    .reset  (reset),
    .busReq (busReq),
    .hwdata (hwdata),
    .hwstrb (hwstrb),
    .hready (hready),
    .hrdata (hrdata),
    .hresp  (hresp)
  );

endmodule

`default_nettype wire

// ==== design/coreBusPkg.sv ====
// Core-side bus definitions
// Instruction line types and the burst final-beat lookup
`default_nettype none

package coreBusPkg;

  // Words per instruction line
  localparam int unsigned lineBeats = 4;

  // Line address, byte address bits 31:4
  typedef logic [27:0] lineAddrT;

  // One fetched line, word 0 at the lowest address
  typedef ahbLitePkg::hDataT [lineBeats-1:0] fetchLineT;

  // Index of the final beat of a burst
  function automatic logic [3:0] burstLastBeat(input ahbLitePkg::hBurstT burst);
    logic [3:0] last;
    case (burst)
      ahbLitePkg::INCR4:  last = 4'd3;
      ahbLitePkg::INCR8:  last = 4'd7;
      ahbLitePkg::INCR16: last = 4'd15;
      // SINGLE, and INCR of unknown length ends after its first beat
      default:            last = 4'd0;
    endcase
    return last;
  endfunction

endpackage

`default_nettype wire

// ==== design/ifuFetcher.sv ====
// Instruction fetch unit bus side
// Issues one INCR4 read burst per fetch request and collects the four
// returned words into a line, flagging any error response
`default_nettype none

module ifuFetcher (
  input  wire logic                 clk,
  input  wire logic                 reset,
  // Core side
  input  wire logic                 fetchStart,
  input  wire coreBusPkg::lineAddrT fetchAddr,
  output logic                      fetchBusy,
  output logic                      fetchDone,
  output logic                      fetchError,
  output coreBusPkg::fetchLineT     fetchLine,
  // AHB manager side
  output ahbLitePkg::ahbReqT        ifuReq,
  input  wire logic                 ifuHready,
  input  wire ahbLitePkg::hDataT    hrdata,
  input  wire logic                 hresp
);

  typedef enum logic [1:0] {IDLE, ADDR, LAST} fetchStateT;
  typedef logic [$clog2(coreBusPkg::lineBeats)-1:0] beatIdxT;

  localparam beatIdxT LastBeat = beatIdxT'(coreBusPkg::lineBeats - 1);

  fetchStateT           state;
  coreBusPkg::lineAddrT lineAddr;
  // Address-phase and data-phase beat counters
  beatIdxT              addrBeat;
  beatIdxT              dataBeat;
  logic                 dataPending;
  logic                 addrAccept;
  logic                 dataDone;
  logic                 lastData;

  assign addrAccept = (state == ADDR) && ifuHready;
  // Data phase ends on the next hready after its address
  assign dataDone   = dataPending && ifuHready;
  assign lastData   = dataDone && (dataBeat == LastBeat);
  assign fetchBusy  = state != IDLE;

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  always_comb begin
    ifuReq.haddr  = {lineAddr, addrBeat, 2'b00};
    ifuReq.hburst = ahbLitePkg::INCR4;
    ifuReq.hsize  = ahbLitePkg::hSizeWord;
    ifuReq.hwrite = 1'b0;
    // First beat NONSEQ, the rest SEQ
    if (state != ADDR) begin
      ifuReq.htrans = ahbLitePkg::IDLE;
    end else if (addrBeat == '0) begin
      ifuReq.htrans = ahbLitePkg::NONSEQ;
    end else begin
      ifuReq.htrans = ahbLitePkg::SEQ;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      addrBeat    <= '0;
      dataBeat    <= '0;
      dataPending <= 1'b0;
      fetchDone   <= 1'b0;
      fetchError  <= 1'b0;
    end else begin
      fetchDone <= lastData;
      case (state)
        IDLE: begin
          if (fetchStart) begin
            state      <= ADDR;
            fetchError <= 1'b0;
          end
        end
        ADDR: begin
          if (addrAccept && (addrBeat == LastBeat)) begin
            state <= LAST;
          end
        end
        LAST: begin
          if (lastData) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
      // Both counters wrap to zero at the end of a line
      if (addrAccept) begin
        addrBeat <= addrBeat + 1'b1;
      end
      if (addrAccept) begin
        dataPending <= 1'b1;
      end else if (dataDone) begin
        dataPending <= 1'b0;
      end
      if (dataDone) begin
        dataBeat <= dataBeat + 1'b1;
        // Sticky until the next fetch
        if (hresp) begin
          fetchError <= 1'b1;
        end
      end
    end
  end

  // Line address and returned words
  always_ff @(posedge clk) begin
    if ((state == IDLE) && fetchStart) begin
      lineAddr <= fetchAddr;
    end
    if (dataDone) begin
      fetchLine[dataBeat] <= hrdata;
    end
  end

  // Address phase held through wait states and arbitration
  assert property (@(posedge clk) disable iff (reset)
    (ifuReq.htrans != ahbLitePkg::IDLE && !ifuHready) |=> $stable(ifuReq));

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tests
design/ahbLitePkg.sv
design/coreBusPkg.sv
design/ifuFetcher.sv
design/ahbMultiManager.sv
design/ahbMemory.sv
design/ahbSubsystem.sv
tests/ahbSubsystemTb.sv

// ==== tests/ahbSubsystemTbTasks.svh ====
// Testbench helpers for the AHB-Lite subsystem
// LCG, reference byte memory, LSU and fetch drivers, compare task
`ifndef AHB_SUBSYSTEM_TB_TASKS_SVH
`define AHB_SUBSYSTEM_TB_TASKS_SVH

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      errorCount++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference memory
  ////////////////////////////////////////////////////////////

  // Writes outside the populated range are dropped
  task automatic refWrite(input ahbLitePkg::hAddrT addr, input ahbLitePkg::hDataT data,
                          input ahbLitePkg::hStrbT strb);
    ahbLitePkg::hAddrT base;
    base = {addr[31:2], 2'b00};
    if (base < MemBytes) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          refMem[base + b] = data[8*b +: 8];
        end
      end
    end
  endtask

  // Zero outside the populated range
  function automatic ahbLitePkg::hDataT refReadWord(input ahbLitePkg::hAddrT addr);
    ahbLitePkg::hAddrT base;
    ahbLitePkg::hDataT word;
    base = {addr[31:2], 2'b00};
    word = '0;
    if (base < MemBytes) begin
      for (int b = 0; b < 4; b++) begin
        word[8*b +: 8] = refMem[base + b];
      end
    end
    return word;
  endfunction

  ////////////////////////////////////////////////////////////
  // Drivers, entered and left right after a rising edge
  ////////////////////////////////////////////////////////////

  // One SINGLE word transfer on the LSU port
  task automatic lsuTransfer(input logic write, input ahbLitePkg::hAddrT addr,
                             input ahbLitePkg::hDataT wdata, input ahbLitePkg::hStrbT strb,
                             output ahbLitePkg::hDataT rdata, output logic resp);
    int unsigned        cycles;
    ahbLitePkg::ahbReqT req;
    req.haddr  = addr;
    req.htrans = ahbLitePkg::NONSEQ;
    req.hburst = ahbLitePkg::SINGLE;
    req.hsize  = ahbLitePkg::hSizeWord;
    req.hwrite = write;
    lsuReq <= req;
    // Address phase
    cycles = 0;
    @(negedge clk);
    while (!lsuHready && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!lsuHready) begin
      abortRun("LSU address phase was never accepted");
    end
    @(posedge clk);
    lsuReq   <= '0;
    lsuWdata <= wdata;
    lsuWstrb <= strb;
    // Data phase ends on the next hready
    cycles = 0;
    @(negedge clk);
    while (!lsuHready && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!lsuHready) begin
      abortRun("LSU data phase never completed");
    end
    rdata = lsuHrdata;
    resp  = lsuHresp;
    @(posedge clk);
  endtask

  // Single-cycle start strobe, fetcher is idle here
  task automatic startFetch(input ahbLitePkg::hAddrT addr);
    fetchStart <= 1'b1;
    fetchAddr  <= addr[31:4];
    @(posedge clk);
    fetchStart <= 1'b0;
  endtask

  task automatic waitFetchDone(output coreBusPkg::fetchLineT line, output logic err);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while (!fetchDone && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!fetchDone) begin
      abortRun("line fetch never signalled done");
    end
    line = fetchLine;
    err  = fetchError;
    @(posedge clk);
  endtask

  // Words in address order, then the error flag
  task automatic checkLine(input string name, input ahbLitePkg::hAddrT addr,
                           input logic expErr, input coreBusPkg::fetchLineT line,
                           input logic err);
    ahbLitePkg::hAddrT base;
    base = {addr[31:4], 4'h0};
    for (int i = 0; i < coreBusPkg::lineBeats; i++) begin
      checkValue($sformatf("%s word%0d", name, i), refReadWord(base + 32'(4 * i)), line[i]);
    end
    checkValue({name, " error"}, 32'(expErr), 32'(err));
  endtask

`endif

// ==== tests/ahbSubsystemTb.sv ====
// Testbench for the two-manager AHB-Lite subsystem
// Clock and reset, stimulus table, row loop and closing report
`default_nettype none

module ahbSubsystemTb;

  localparam int unsigned WaitStates = 1;
  localparam int unsigned MemWords   = 256;
  localparam int unsigned MemBytes   = MemWords * 4;
  // Cycles allowed for any single wait
  localparam int unsigned Timeout    = 100;
  localparam int unsigned NumRows    = 13;
  // LSU side of a concurrent row writes a quarter of the memory away
  localparam logic [31:0] ConcOffset = 32'h100;
  // Data access, privileged, not bufferable, not cacheable
  localparam logic [3:0]  ExpHprot   = 4'b0011;

  typedef enum logic [1:0] {lsuWrite, lsuRead, fetch, concurrent} stimKindT;

  // One table row with its expected response
  typedef struct {
    string             name;
    stimKindT          kind;
    ahbLitePkg::hAddrT addr;
    ahbLitePkg::hDataT wdata;
    ahbLitePkg::hStrbT strb;
    logic              expErr;
  } stimRowT;

  logic                  clk;
  logic                  reset;
  logic                  fetchStart;
  coreBusPkg::lineAddrT  fetchAddr;
  logic                  fetchBusy;
  logic                  fetchDone;
  logic                  fetchError;
  coreBusPkg::fetchLineT fetchLine;
  ahbLitePkg::ahbReqT    lsuReq;
  ahbLitePkg::hDataT     lsuWdata;
  ahbLitePkg::hStrbT     lsuWstrb;
  logic                  lsuHready;
  ahbLitePkg::hDataT     lsuHrdata;
  logic                  lsuHresp;
  logic [3:0]            hprot;

  stimRowT     stimTable [NumRows];
  // Reference memory with one entry per byte
  logic [7:0]  refMem [MemBytes];
  int unsigned errorCount;
  logic [31:0] lcgState;

  ahbSubsystem #(
    .WaitStates (WaitStates),
    .MemWords   (MemWords)
  ) dut0 (
    .clk        (clk),
    .reset      (reset),
    .fetchStart (fetchStart),
    .fetchAddr  (fetchAddr),
    .fetchBusy  (fetchBusy),
    .fetchDone  (fetchDone),
    .fetchError (fetchError),
    .fetchLine  (fetchLine),
    .lsuReq     (lsuReq),
    .lsuWdata   (lsuWdata),
    .lsuWstrb   (lsuWstrb),
    .lsuHready  (lsuHready),
    .lsuHrdata  (lsuHrdata),
    .lsuHresp   (lsuHresp),
    .hprot      (hprot)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  task automatic closeRun();
    $display("Checks done, %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic abortRun(input string what);
    $display("Timeout: %s", what);
    errorCount++;
    closeRun();
  endtask

  `include "ahbSubsystemTbTasks.svh"

  function automatic stimRowT makeRow(input string name, input stimKindT kind,
                                      input ahbLitePkg::hAddrT addr,
                                      input ahbLitePkg::hDataT wdata,
                                      input ahbLitePkg::hStrbT strb,
                                      input logic expErr);
    stimRowT row;
    row.name   = name;
    row.kind   = kind;
    row.addr   = addr;
    row.wdata  = wdata;
    row.strb   = strb;
    row.expErr = expErr;
    return row;
  endfunction

  task automatic fillTable();
    // Partial strobes then read-back of the merged word
    stimTable[0]  = makeRow("wrByte0", lsuWrite, 32'h010, 32'ha5a5a5a5, 4'b0001, 1'b0);
    stimTable[1]  = makeRow("wrMidBytes", lsuWrite, 32'h010, 32'h12345678, 4'b0110, 1'b0);
    stimTable[2]  = makeRow("rdMerged", lsuRead, 32'h010, '0, '0, 1'b0);
    stimTable[3]  = makeRow("wrUpperHalf", lsuWrite, 32'h024, 32'hcafebeef, 4'b1100, 1'b0);
    stimTable[4]  = makeRow("rdUpperHalf", lsuRead, 32'h024, '0, '0, 1'b0);
    stimTable[5]  = makeRow("wrNoStrobe", lsuWrite, 32'h028, 32'hffffffff, 4'b0000, 1'b0);
    stimTable[6]  = makeRow("rdNoStrobe", lsuRead, 32'h028, '0, '0, 1'b0);
    // Line fetches over the words written above
    stimTable[7]  = makeRow("fetchLine1", fetch, 32'h010, '0, '0, 1'b0);
    stimTable[8]  = makeRow("fetchLine2", fetch, 32'h020, '0, '0, 1'b0);
    // Same-cycle fetch and LSU write
    stimTable[9]  = makeRow("fetchWithWrite", concurrent, 32'h030, 32'h0badf00d, 4'hf, 1'b0);
    stimTable[10] = makeRow("rdConcWrite", lsuRead, 32'h130, '0, '0, 1'b0);
    // Beyond the populated range
    stimTable[11] = makeRow("rdOutOfRange", lsuRead, 32'h400, '0, '0, 1'b1);
    stimTable[12] = makeRow("fetchOutOfRange", fetch, 32'h400, '0, '0, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // Row execution
  ////////////////////////////////////////////////////////////

  task automatic applyRow(input stimRowT row);
    ahbLitePkg::hDataT     rdata;
    logic                  resp;
    coreBusPkg::fetchLineT line;
    logic                  lineErr;
    ahbLitePkg::hAddrT     lsuAddr;
    case (row.kind)
      lsuWrite: begin
        lsuTransfer(1'b1, row.addr, row.wdata, row.strb, rdata, resp);
        refWrite(row.addr, row.wdata, row.strb);
        checkValue({row.name, " resp"}, 32'(row.expErr), 32'(resp));
      end
      lsuRead: begin
        lsuTransfer(1'b0, row.addr, '0, '0, rdata, resp);
        checkValue({row.name, " data"}, refReadWord(row.addr), rdata);
        checkValue({row.name, " resp"}, 32'(row.expErr), 32'(resp));
      end
      fetch: begin
        startFetch(row.addr);
        waitFetchDone(line, lineErr);
        checkLine(row.name, row.addr, row.expErr, line, lineErr);
      end
      default: begin
        // Fetch and LSU address phases meet in the same cycle
        lsuAddr = row.addr + ConcOffset;
        startFetch(row.addr);
        fork
          lsuTransfer(1'b1, lsuAddr, row.wdata, row.strb, rdata, resp);
          waitFetchDone(line, lineErr);
        join
        refWrite(lsuAddr, row.wdata, row.strb);
        checkValue({row.name, " resp"}, 32'(row.expErr), 32'(resp));
        checkLine(row.name, row.addr, row.expErr, line, lineErr);
      end
    endcase
  endtask

  initial begin
    ahbLitePkg::hDataT rdata;
    ahbLitePkg::hDataT data;
    logic              resp;
    errorCount = 0;
    lcgState   = 32'hdee8;
    reset      = 1'b1;
    fetchStart = 1'b0;
    fetchAddr  = '0;
    lsuReq     = '0;
    lsuWdata   = '0;
    lsuWstrb   = '0;
    fillTable();
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // Idle state right after reset
    @(negedge clk);
    checkValue("idleLsuHready", 32'd1, 32'(lsuHready));
    checkValue("idleFetchBusy", 32'd0, 32'(fetchBusy));
    checkValue("idleFetchDone", 32'd0, 32'(fetchDone));
    checkValue("idleFetchError", 32'd0, 32'(fetchError));
    checkValue("idleHprot", 32'(ExpHprot), 32'(hprot));
    @(posedge clk);

    // Random contents for every word
    for (int w = 0; w < MemWords; w++) begin
      data = lcgNext();
      lsuTransfer(1'b1, 32'(w * 4), data, 4'hf, rdata, resp);
      refWrite(32'(w * 4), data, 4'hf);
    end

    for (int r = 0; r < NumRows; r++) begin
      applyRow(stimTable[r]);
    end
    closeRun();
  end

endmodule

`default_nettype wire
